/* program.hex */
// One RV32I instruction word per line, in hex, from address 0 upward
00500093
ffd00113
002081b3
40208233
0020f2b3
0020e333
001123b3
00602423
00802403
00208463
00318463
06300493
00700013
00800533
00000063
00000013

/* filelist.f */
src/riscvPkg.sv
src/instMem.sv
src/registerFile.sv
src/dataMem.sv
src/mainControl.sv
src/alu.sv
src/immGen.sv
src/fetchUnit.sv
src/singleCpu.sv
verif/singleCpu_sva.sv
verif/singleCpuTb.sv

/* Bender.yml */
package:
  name: single_cpu

sources:
  - src/riscvPkg.sv
  - src/instMem.sv
  - src/registerFile.sv
  - src/dataMem.sv
  - src/mainControl.sv
  - src/alu.sv
  - src/immGen.sv
  - src/fetchUnit.sv
  - src/singleCpu.sv
  - target: test
    files:
      - verif/singleCpu_sva.sv
      - verif/singleCpuTb.sv

/* verif/singleCpuTb.sv */
`default_nettype none

module singleCpuTb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD     = 10;
    localparam int RESET_CYCLES   = 16;
    localparam int NUM_ROWS       = 20;
    localparam int HALT_ROWS      = 7;                       // Rows spent in the halt loop
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_ROWS + 20;

    // Expected view of one retired instruction
    typedef struct packed {
        riscvPkg::word_t   pc;
        riscvPkg::word_t   instruction;
        riscvPkg::retire_t retire;
    } row_t;

    logic              CLK;
    logic              reset;
    riscvPkg::word_t   instruction;
    riscvPkg::word_t   pc;
    riscvPkg::retire_t retire;

    row_t  rows[$];
    string labels[$];
    int    cycleCount;

    singleCpu u_singleCpu (
        .CLK(CLK), .reset(reset), .instruction(instruction), .pc(pc), .retire(retire)
    );

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    task automatic addRow(input string label, input riscvPkg::word_t pcExp,
                          input riscvPkg::word_t instExp, input logic regWrite,
                          input riscvPkg::regAddr_t rd, input riscvPkg::word_t wbData);
        row_t r;
        r.pc              = pcExp;
        r.instruction     = instExp;
        r.retire.regWrite = regWrite;
        r.retire.rd       = rd;
        r.retire.wbData   = wbData;
        rows.push_back(r);
        labels.push_back(label);
    endtask

    // Retirements of program.hex, one row per cycle after reset
    task automatic buildTable();
        addRow("addi x1,x0,5", 32'h00, 32'h0050_0093, 1'b1, 5'd1, 32'h0000_0005);
        addRow("addi x2,x0,-3", 32'h04, 32'hffd0_0113, 1'b1, 5'd2, 32'hffff_fffd);
        addRow("add x3,x1,x2", 32'h08, 32'h0020_81b3, 1'b1, 5'd3, 32'h0000_0002);
        addRow("sub x4,x1,x2", 32'h0c, 32'h4020_8233, 1'b1, 5'd4, 32'h0000_0008);
        addRow("and x5,x1,x2", 32'h10, 32'h0020_f2b3, 1'b1, 5'd5, 32'h0000_0005);
        addRow("or x6,x1,x2", 32'h14, 32'h0020_e333, 1'b1, 5'd6, 32'hffff_fffd);
        addRow("slt x7,x2,x1", 32'h18, 32'h0011_23b3, 1'b1, 5'd7, 32'h0000_0001);
        // Store shows its address on the trace and imm[4:0] in the rd field
        addRow("sw x6,8(x0)", 32'h1c, 32'h0060_2423, 1'b0, 5'd8, 32'h0000_0008);
        addRow("lw x8,8(x0)", 32'h20, 32'h0080_2403, 1'b1, 5'd8, 32'hffff_fffd);
        addRow("beq x1,x2,8", 32'h24, 32'h0020_8463, 1'b0, 5'd8, 32'h0000_0008); // 5 - (-3)
        addRow("beq x3,x3,8", 32'h28, 32'h0031_8463, 1'b0, 5'd8, 32'h0000_0000); // Skips 0x2c
        addRow("addi x0,x0,7", 32'h30, 32'h0070_0013, 1'b1, 5'd0, 32'h0000_0007);
        addRow("add x10,x0,x8", 32'h34, 32'h0080_0533, 1'b1, 5'd10, 32'hffff_fffd);
        for (int i = 0; i < HALT_ROWS; i++) begin
            addRow($sformatf("halt %0d", i), 32'h38, 32'h0000_0063, 1'b0, 5'd0, 32'h0);
        end
    endtask

    task automatic checkWord(input string name, input riscvPkg::word_t expected,
                             input riscvPkg::word_t actual);
        if (actual !== expected) begin
            $display("** Error: %s: expected %h, actual %h", name, expected, actual);
            $display("Done: errors found");
            $fatal(1, "Stopped at the first failed check");
        end
    endtask

    task automatic checkRetire(input string name, input riscvPkg::retire_t expected,
                               input riscvPkg::retire_t actual);
        string expText;
        string actText;
        if (actual !== expected) begin
            expText = $sformatf("regWrite=%b rd=%0d wbData=%h",
                                expected.regWrite, expected.rd, expected.wbData);
            actText = $sformatf("regWrite=%b rd=%0d wbData=%h",
                                actual.regWrite, actual.rd, actual.wbData);
            $display("** Error: %s: expected %s, actual %s", name, expText, actText);
            $display("Done: errors found");
            $fatal(1, "Stopped at the first failed check");
        end
    endtask

    initial begin
        reset = 1'b1;
        buildTable();

        for (int c = 0; c < RESET_CYCLES; c++) begin
            @(negedge CLK);
            checkWord("reset pc", riscvPkg::RESET_PC, pc);
            checkWord("reset regWrite", '0, riscvPkg::word_t'(retire.regWrite));
        end
        reset = 1'b0;                                   // Released on a falling edge

        for (int i = 0; i < NUM_ROWS; i++) begin
            if (i > 0) begin
                @(negedge CLK);
            end
            #1;                                         // Let the decode path settle
            checkWord({labels[i], " pc"}, rows[i].pc, pc);
            checkWord({labels[i], " instruction"}, rows[i].instruction, instruction);
            checkRetire({labels[i], " retire"}, rows[i].retire, retire);
        end

        if (u_singleCpu.u_sva.failCount == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            $display("Assertion failures seen: %0d", u_singleCpu.u_sva.failCount);
            $display("Done: errors found");
            $fatal(1, "Assertions failed during the run");
        end
    end

    // Watchdog
    initial begin
        cycleCount = 0;
        while (cycleCount < TIMEOUT_CYCLES) begin
            @(posedge CLK);
            cycleCount++;
        end
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Done: errors found");
        $fatal(1, "Timeout");
    end

endmodule

`default_nettype wire

/* verif/singleCpu_sva.sv */
`default_nettype none

module singleCpuSva (
    input logic              CLK,
    input logic              reset,
    input riscvPkg::word_t   pc,
    input riscvPkg::retire_t retire,
    input logic              branchTaken
);

    timeunit 1ns;
    timeprecision 100ps;

    int failCount = 0;      // Read by the testbench at the end

    pcHeldInReset: assert property (@(posedge CLK) reset |=> pc == riscvPkg::RESET_PC)
        else begin
            failCount++;
            $error("pc is not at the reset address while reset is high");
        end

    noWriteInReset: assert property (@(posedge CLK) reset |-> !retire.regWrite)
        else begin
            failCount++;
            $error("A register write retired during reset");
        end

    pcAligned: assert property (@(posedge CLK) disable iff (reset) pc[1:0] == 2'b00)
        else begin
            failCount++;
            $error("pc is not word aligned");
        end

    // Sequential fetch whenever no branch is taken
    pcPlusFour: assert property (@(posedge CLK) disable iff (reset)
        !branchTaken |=> pc == $past(pc) + riscvPkg::word_t'(4))
        else begin
            failCount++;
            $error("pc did not advance by four without a taken branch");
        end

endmodule

bind singleCpu singleCpuSva u_sva (
    .CLK(CLK), .reset(reset), .pc(pc), .retire(retire), .branchTaken(branchTaken)
);

`default_nettype wire

/* src/singleCpu.sv */
`default_nettype none

module singleCpu (
    input  logic              CLK,
    input  logic              reset,
    output riscvPkg::word_t   instruction,
    output riscvPkg::word_t   pc,
    output riscvPkg::retire_t retire
);

    riscvPkg::opcode_t  opcode;
    riscvPkg::regAddr_t rs1;
    riscvPkg::regAddr_t rs2;
    riscvPkg::regAddr_t rd;
    logic [2:0]         funct3;
    logic               funct7b5;

    riscvPkg::ctrl_t    ctrl;
    riscvPkg::word_t    imm;
    riscvPkg::word_t    rs1Data;
    riscvPkg::word_t    rs2Data;
    riscvPkg::word_t    aluB;
    riscvPkg::word_t    aluResult;
    logic               zero;
    riscvPkg::word_t    memRdData;
    riscvPkg::word_t    wbData;
    logic               branchTaken;

    // Instruction fields
    assign opcode = riscvPkg::opcode_t'(instruction[6:0]);
    assign rd     = instruction[11:7];
    assign funct3 = instruction[14:12];
    assign rs1    = instruction[19:15];
    assign rs2    = instruction[24:20];

    // Only R-type may select sub, so addi with a negative immediate stays an add
    assign funct7b5 = instruction[30] & (opcode == riscvPkg::OP);

    fetchUnit u_fetchUnit (
        .CLK(CLK), .reset(reset), .branchTaken(branchTaken), .imm(imm), .pc(pc)
    );

    instMem u_instMem (.pc(pc), .instruction(instruction));

    mainControl u_mainControl (.reset(reset), .opcode(opcode), .ctrl(ctrl));

    immGen u_immGen (.instruction(instruction), .imm(imm));

    registerFile u_registerFile (
        .CLK(CLK), .reset(reset), .rs1(rs1), .rs2(rs2), .rd(rd),
        .wbData(wbData), .regWrite(ctrl.regWrite), .rs1Data(rs1Data), .rs2Data(rs2Data)
    );

    assign aluB = ctrl.aluSrcImm ? imm : rs2Data;   // Operand b select

    alu u_alu (
        .aluClass(ctrl.aluClass), .funct3(funct3), .funct7b5(funct7b5),
        .a(rs1Data), .b(aluB), .result(aluResult), .zero(zero)
    );

    dataMem u_dataMem (
        .CLK(CLK), .reset(reset), .addr(aluResult), .wrData(rs2Data),
        .memWrite(ctrl.memWrite), .rdData(memRdData)
    );

    assign wbData      = ctrl.memToReg ? memRdData : aluResult;
    assign branchTaken = ctrl.branch & zero;        // beq only

    // Writeback trace
    assign retire = '{regWrite: ctrl.regWrite, rd: rd, wbData: wbData};

endmodule

`default_nettype wire

/* src/fetchUnit.sv */
`default_nettype none

module fetchUnit (
    input  logic            CLK,
    input  logic            reset,
    input  logic            branchTaken,
    input  riscvPkg::word_t imm,
    output riscvPkg::word_t pc
);

    riscvPkg::word_t pcPlus4;
    riscvPkg::word_t branchTarget;
    riscvPkg::word_t nextPc;

    assign pcPlus4      = pc + riscvPkg::word_t'(4);
    assign branchTarget = pc + imm;     // Immediate is already shifted

    // Next PC select
    assign nextPc = branchTaken ? branchTarget : pcPlus4;

    always_ff @(posedge CLK) begin
        if (reset) begin
            pc <= riscvPkg::RESET_PC;
        end else begin
            pc <= nextPc;
        end
    end

endmodule

`default_nettype wire

/* src/immGen.sv */
`default_nettype none

module immGen (
    input  riscvPkg::word_t instruction,
    output riscvPkg::word_t imm
);

    riscvPkg::opcode_t opcode;

    assign opcode = riscvPkg::opcode_t'(instruction[6:0]);

    always_comb begin
        case (opcode)
            riscvPkg::OPIMM,
            riscvPkg::LOAD: begin
                imm = {{20{instruction[31]}}, instruction[31:20]};    // I layout
            end
            riscvPkg::STORE: begin
                imm = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
            end
            riscvPkg::BRANCH: begin
                // B layout, bit 0 always zero
                imm = {{19{instruction[31]}}, instruction[31], instruction[7],
                       instruction[30:25], instruction[11:8], 1'b0};
            end
            default: imm = '0;                                        // R-type has none
        endcase
    end

endmodule

`default_nettype wire

/* src/alu.sv */
`default_nettype none

module alu (
    input  riscvPkg::aluClass_t aluClass,
    input  logic [2:0]          funct3,
    input  logic                funct7b5,
    input  riscvPkg::word_t     a,
    input  riscvPkg::word_t     b,
    output riscvPkg::word_t     result,
    output logic                zero
);

    riscvPkg::aluOp_t aluOp;
    logic             lessThan;

    // ALU control decode
    always_comb begin
        case (aluClass)
            riscvPkg::CLASS_ADD: aluOp = riscvPkg::ALU_ADD;
            riscvPkg::CLASS_SUB: aluOp = riscvPkg::ALU_SUB;
            riscvPkg::CLASS_FUNCT: begin
                case (funct3)
                    riscvPkg::F3_ADDSUB: aluOp = funct7b5 ? riscvPkg::ALU_SUB : riscvPkg::ALU_ADD;
                    riscvPkg::F3_SLT:    aluOp = riscvPkg::ALU_SLT;
                    riscvPkg::F3_OR:     aluOp = riscvPkg::ALU_OR;
                    riscvPkg::F3_AND:    aluOp = riscvPkg::ALU_AND;
                    default:             aluOp = riscvPkg::ALU_ADD;
                endcase
            end
            default: aluOp = riscvPkg::ALU_ADD;
        endcase
    end

    assign lessThan = $signed(a) < $signed(b);

    always_comb begin
        case (aluOp)
            riscvPkg::ALU_AND: result = a & b;
            riscvPkg::ALU_OR:  result = a | b;
            riscvPkg::ALU_ADD: result = a + b;
            riscvPkg::ALU_SUB: result = a - b;
            riscvPkg::ALU_SLT: result = {{(riscvPkg::XLEN-1){1'b0}}, lessThan};
            default:           result = '0;
        endcase
    end

    assign zero = (result == '0);

endmodule

`default_nettype wire

/* src/mainControl.sv */
`default_nettype none

module mainControl (
    input  logic              reset,
    input  riscvPkg::opcode_t opcode,
    output riscvPkg::ctrl_t   ctrl
);

    always_comb begin
        ctrl = '0;                          // Unknown opcode acts as a no-op
        case (opcode)
            riscvPkg::OP: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluClass = riscvPkg::CLASS_FUNCT;
            end
            riscvPkg::OPIMM: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluClass  = riscvPkg::CLASS_FUNCT;
            end
            riscvPkg::LOAD: begin
                ctrl.regWrite  = 1'b1;
                ctrl.memToReg  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluClass  = riscvPkg::CLASS_ADD;   // Base plus offset
            end
            riscvPkg::STORE: begin
                ctrl.memWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluClass  = riscvPkg::CLASS_ADD;
            end
            riscvPkg::BRANCH: begin
                ctrl.branch   = 1'b1;
                ctrl.aluClass = riscvPkg::CLASS_SUB;    // Zero flag means equal
            end
            default: begin
                ctrl = '0;
            end
        endcase

        // No architectural writes while in reset
        if (reset) begin
            ctrl.regWrite = 1'b0;
            ctrl.memWrite = 1'b0;
        end
    end

endmodule

`default_nettype wire

/* src/dataMem.sv */
`default_nettype none

module dataMem (
    input  logic            CLK,
    input  logic            reset,
    input  riscvPkg::word_t addr,
    input  riscvPkg::word_t wrData,
    input  logic            memWrite,
    output riscvPkg::word_t rdData
);

    riscvPkg::word_t mem [riscvPkg::DMEM_WORDS];

    logic [riscvPkg::DMEM_IDX_W-1:0] wordIdx;

    assign wordIdx = addr[riscvPkg::DMEM_IDX_W+1:2];  // Low two bits ignored

    always_ff @(posedge CLK) begin
        if (reset) begin
            for (int i = 0; i < riscvPkg::DMEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (memWrite) begin
            mem[wordIdx] <= wrData;
        end
    end

    assign rdData = mem[wordIdx];

endmodule

`default_nettype wire

/* src/registerFile.sv */
`default_nettype none

module registerFile (
    input  logic               CLK,
    input  logic               reset,
    input  riscvPkg::regAddr_t rs1,
    input  riscvPkg::regAddr_t rs2,
    input  riscvPkg::regAddr_t rd,
    input  riscvPkg::word_t    wbData,
    input  logic               regWrite,
    output riscvPkg::word_t    rs1Data,
    output riscvPkg::word_t    rs2Data
);

    riscvPkg::word_t regs [riscvPkg::REG_COUNT];

    always_ff @(posedge CLK) begin
        if (reset) begin
            for (int i = 0; i < riscvPkg::REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (regWrite && (rd != '0)) begin
            regs[rd] <= wbData;     // x0 never written
        end
    end

    // Old value is visible during a same-cycle write
    assign rs1Data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2Data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

/* src/instMem.sv */
`default_nettype none

module instMem (
    input  riscvPkg::word_t pc,
    output riscvPkg::word_t instruction
);

    riscvPkg::word_t rom [riscvPkg::IMEM_WORDS];

    logic [riscvPkg::IMEM_IDX_W-1:0] wordIdx;

    // Unloaded words stay zero
    initial begin
        for (int i = 0; i < riscvPkg::IMEM_WORDS; i++) begin
            rom[i] = '0;
        end
        $readmemh("program.hex", rom);
    end

    assign wordIdx = pc[riscvPkg::IMEM_IDX_W+1:2];  // Byte address to word index

    assign instruction = rom[wordIdx];

endmodule

`default_nettype wire

/* src/riscvPkg.sv */
`default_nettype none

package riscvPkg;

    localparam int XLEN       = 32;
    localparam int REG_COUNT  = 32;
    localparam int IMEM_WORDS = 64;          // Program words
    localparam int DMEM_WORDS = 64;          // Data words
    localparam int IMEM_IDX_W = $clog2(IMEM_WORDS);
    localparam int DMEM_IDX_W = $clog2(DMEM_WORDS);

    typedef logic [XLEN-1:0] word_t;         // Data or address word
    typedef logic [4:0]      regAddr_t;      // Register index

    localparam word_t RESET_PC = '0;         // First fetch address

    // Base opcodes of the supported subset
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OPIMM  = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011
    } opcode_t;

    // funct3 codes for R-type and I-type arithmetic
    localparam logic [2:0] F3_ADDSUB = 3'b000;
    localparam logic [2:0] F3_SLT    = 3'b010;
    localparam logic [2:0] F3_OR     = 3'b110;
    localparam logic [2:0] F3_AND    = 3'b111;

    typedef enum logic [1:0] {
        CLASS_ADD   = 2'b00,                 // Address calculation
        CLASS_SUB   = 2'b01,                 // beq compare
        CLASS_FUNCT = 2'b10                  // Taken from funct3 / funct7
    } aluClass_t;

    typedef enum logic [3:0] {
        ALU_AND = 4'b0000,
        ALU_OR  = 4'b0001,
        ALU_ADD = 4'b0010,
        ALU_SUB = 4'b0110,
        ALU_SLT = 4'b0111
    } aluOp_t;

    typedef struct packed {
        logic      regWrite;
        logic      memWrite;
        logic      memToReg;
        logic      aluSrcImm;
        logic      branch;
        aluClass_t aluClass;
    } ctrl_t;

    // One entry per retired instruction
    typedef struct packed {
        logic     regWrite;
        regAddr_t rd;
        word_t    wbData;
    } retire_t;

endpackage

`default_nettype wire
